/* source/video_mixer_macros.svh */
`ifndef VIDEO_MIXER_MACROS_SVH
`define VIDEO_MIXER_MACROS_SVH

// Number of priority control registers.
`define VM_NUM_CTRL 8

// Number of palette words.
`define VM_PAL_DEPTH 1024

// Layer color word width.
`define VM_COLOR_W 14

// CPU word address width.
`define VM_ADDR_W 11

// CPU data and palette word width.
`define VM_DATA_W 16

// Output channel width.
`define VM_CHAN_W 8

`endif

/* source/video_mixer_pkg.sv */
`include "video_mixer_macros.svh"

package video_mixer_pkg;

    // Layer color word, priority group in the top two bits.
    typedef struct packed {
        logic [1:0]               prio_grp;
        logic [`VM_COLOR_W-3:0]   index;
    } color_t;

    // Palette word, 15-bit RGB with the top bit spare.
    typedef struct packed {
        logic       spare;
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } pal_word_t;

    typedef struct packed {
        logic [`VM_CHAN_W-1:0] red;
        logic [`VM_CHAN_W-1:0] green;
        logic [`VM_CHAN_W-1:0] blue;
    } rgb_t;

    // Address bit that splits the palette from the control registers.
    parameter int unsigned MAP_SEL_BIT = 10;

    // Low address bits that index a control register.
    parameter int unsigned CTRL_IDX_W = $clog2(`VM_NUM_CTRL);

    // Low address bits that index a palette word.
    parameter int unsigned PAL_IDX_W = $clog2(`VM_PAL_DEPTH);

endpackage

/* source/reg_bus_if.sv */
`timescale 1ns/1ps
`include "video_mixer_macros.svh"

// Internal CPU bus toward one register-holding block.
interface reg_bus_if;

    logic                   sel;
    logic                   rw;
    logic [`VM_ADDR_W-1:0]  addr;
    logic [1:0]             ds_n;
    logic [`VM_DATA_W-1:0]  wdata;
    logic [`VM_DATA_W-1:0]  rdata;

    modport master (
        output sel,
        output rw,
        output addr,
        output ds_n,
        output wdata,
        input  rdata
    );

    modport slave (
        input  sel,
        input  rw,
        input  addr,
        input  ds_n,
        input  wdata,
        output rdata
    );

endinterface

/* source/cpu_bus_decode.sv */
`timescale 1ns/1ps
`include "video_mixer_macros.svh"

module cpu_bus_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cs,
    input  logic [`VM_ADDR_W-1:0]   cpu_addr,
    input  logic                    cpu_rw,
    input  logic [1:0]              cpu_ds_n,
    input  logic [`VM_DATA_W-1:0]   cpu_din,
    output logic [`VM_DATA_W-1:0]   cpu_dout,
    reg_bus_if.master               prio_bus,
    reg_bus_if.master               pal_bus
);

    import video_mixer_pkg::*;

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_PRIO,
        TGT_PAL
    } target_t;

    logic    pal_hit;
    logic    prio_hit;
    target_t rd_target;

    // Palette below bit 10, control registers in the first eight words above it.
    assign pal_hit  = !cpu_addr[MAP_SEL_BIT];
    assign prio_hit = cpu_addr[MAP_SEL_BIT] &&
                      (cpu_addr[MAP_SEL_BIT-1:CTRL_IDX_W] == '0);

    assign prio_bus.sel   = cs && prio_hit;
    assign prio_bus.rw    = cpu_rw;
    assign prio_bus.addr  = cpu_addr;
    assign prio_bus.ds_n  = cpu_ds_n;
    assign prio_bus.wdata = cpu_din;

    assign pal_bus.sel    = cs && pal_hit;
    assign pal_bus.rw     = cpu_rw;
    assign pal_bus.addr   = cpu_addr;
    assign pal_bus.ds_n   = cpu_ds_n;
    assign pal_bus.wdata  = cpu_din;

    // Remember where the last read went, the blocks hold their read data.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_target <= TGT_NONE;
        end else if (cs && cpu_rw) begin
            if (prio_hit) begin
                rd_target <= TGT_PRIO;
            end else if (pal_hit) begin
                rd_target <= TGT_PAL;
            end else begin
                rd_target <= TGT_NONE;
            end
        end
    end

    always_comb begin
        case (rd_target)
            TGT_PRIO: cpu_dout = prio_bus.rdata;
            TGT_PAL:  cpu_dout = pal_bus.rdata;
            default:  cpu_dout = '0;
        endcase
    end

endmodule

/* source/prio_mixer.sv */
`timescale 1ns/1ps
`include "video_mixer_macros.svh"

module prio_mixer (
    input  logic                    clk,
    input  logic                    reset,
    reg_bus_if.slave                bus,
    input  logic                    pixel_valid,
    input  video_mixer_pkg::color_t layer0,
    input  video_mixer_pkg::color_t layer1,
    input  video_mixer_pkg::color_t layer2,
    output logic                    mix_valid,
    output video_mixer_pkg::color_t mix_color
);

    import video_mixer_pkg::*;

    logic [`VM_DATA_W-1:0] ctrl [`VM_NUM_CTRL];
    logic [CTRL_IDX_W-1:0] idx;
    logic [1:0]            sel2;
    logic [3:0]            prio0;
    logic [3:0]            prio1;
    logic [3:0]            prio2;
    color_t                winner;

    assign idx = bus.addr[CTRL_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `VM_NUM_CTRL; i++) begin
                ctrl[i] <= '0;
            end
        end else if (bus.sel && !bus.rw) begin
            if (!bus.ds_n[1]) begin
                ctrl[idx][15:8] <= bus.wdata[15:8];
            end
            if (!bus.ds_n[0]) begin
                ctrl[idx][7:0] <= bus.wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.sel && bus.rw) begin
            bus.rdata <= ctrl[idx];
        end
    end

    // Layer 2 has no group of its own here, register 0 picks its nibble.
    assign sel2  = ctrl[0][15:14];
    assign prio0 = ctrl[2][{layer0.prio_grp, 2'b00} +: 4];
    assign prio1 = ctrl[3][{layer1.prio_grp, 2'b00} +: 4];
    assign prio2 = ctrl[4][{sel2, 2'b00} +: 4];

    // Ties go to the lower layer.
    always_comb begin
        if (prio1 > prio0) begin
            if (prio2 > prio1) begin
                winner = layer2;
            end else begin
                winner = layer1;
            end
        end else if (prio2 > prio0) begin
            winner = layer2;
        end else begin
            winner = layer0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= pixel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            mix_color <= winner;
        end
    end

endmodule

/* source/palette_lookup.sv */
`timescale 1ns/1ps
`include "video_mixer_macros.svh"

module palette_lookup (
    input  logic                    clk,
    input  logic                    reset,
    reg_bus_if.slave                bus,
    input  logic                    mix_valid,
    input  video_mixer_pkg::color_t mix_color,
    output logic                    rgb_valid,
    output video_mixer_pkg::rgb_t   rgb
);

    import video_mixer_pkg::*;

    pal_word_t            ram [`VM_PAL_DEPTH];
    logic [PAL_IDX_W-1:0] cpu_idx;
    logic [PAL_IDX_W-1:0] vid_idx;

    // Replicate the top bits so full scale stays full scale.
    function automatic rgb_t expand(input pal_word_t w);
        rgb_t c;
        c.red   = {w.red,   w.red[4:2]};
        c.green = {w.green, w.green[4:2]};
        c.blue  = {w.blue,  w.blue[4:2]};
        return c;
    endfunction

    assign cpu_idx = bus.addr[PAL_IDX_W-1:0];
    assign vid_idx = mix_color.index[PAL_IDX_W-1:0];

    // Both read ports see the word from before a same-edge CPU write.
    always_ff @(posedge clk) begin
        if (bus.sel) begin
            if (bus.rw) begin
                bus.rdata <= ram[cpu_idx];
            end else begin
                if (!bus.ds_n[1]) begin
                    ram[cpu_idx][15:8] <= bus.wdata[15:8];
                end
                if (!bus.ds_n[0]) begin
                    ram[cpu_idx][7:0] <= bus.wdata[7:0];
                end
            end
        end
        if (mix_valid) begin
            rgb <= expand(ram[vid_idx]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= mix_valid;
        end
    end

endmodule

/* source/video_mixer_top.sv */
`timescale 1ns/1ps
`include "video_mixer_macros.svh"

module video_mixer_top (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    cs,
    input  logic [`VM_ADDR_W-1:0]   cpu_addr,
    input  logic                    cpu_rw,
    input  logic [1:0]              cpu_ds_n,
    input  logic [`VM_DATA_W-1:0]   cpu_din,
    output logic [`VM_DATA_W-1:0]   cpu_dout,

    input  logic                    pixel_valid,
    input  logic [`VM_COLOR_W-1:0]  layer0,
    input  logic [`VM_COLOR_W-1:0]  layer1,
    input  logic [`VM_COLOR_W-1:0]  layer2,

    output logic                    rgb_valid,
    output logic [`VM_CHAN_W-1:0]   red,
    output logic [`VM_CHAN_W-1:0]   green,
    output logic [`VM_CHAN_W-1:0]   blue
);

    import video_mixer_pkg::*;

    color_t layer0_c;
    color_t layer1_c;
    color_t layer2_c;
    color_t mix_color;
    logic   mix_valid;
    rgb_t   rgb;

    reg_bus_if prio_bus ();
    reg_bus_if pal_bus ();

    assign layer0_c = color_t'(layer0);
    assign layer1_c = color_t'(layer1);
    assign layer2_c = color_t'(layer2);

    cpu_bus_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .cs       (cs),
        .cpu_addr (cpu_addr),
        .cpu_rw   (cpu_rw),
        .cpu_ds_n (cpu_ds_n),
        .cpu_din  (cpu_din),
        .cpu_dout (cpu_dout),
        .prio_bus (prio_bus.master),
        .pal_bus  (pal_bus.master)
    );

    prio_mixer u_mixer (
        .clk         (clk),
        .reset       (reset),
        .bus         (prio_bus.slave),
        .pixel_valid (pixel_valid),
        .layer0      (layer0_c),
        .layer1      (layer1_c),
        .layer2      (layer2_c),
        .mix_valid   (mix_valid),
        .mix_color   (mix_color)
    );

    palette_lookup u_palette (
        .clk       (clk),
        .reset     (reset),
        .bus       (pal_bus.slave),
        .mix_valid (mix_valid),
        .mix_color (mix_color),
        .rgb_valid (rgb_valid),
        .rgb       (rgb)
    );

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

endmodule

/* dv/video_mixer_assert.sv */
`timescale 1ns/1ps

module video_mixer_assert (
    input logic clk,
    input logic reset,
    input logic pixel_valid,
    input logic mix_valid,
    input logic rgb_valid,
    input logic prio_sel,
    input logic pal_sel
);

    // Two-stage pixel pipeline.
    assert property (@(posedge clk) disable iff (reset) pixel_valid |-> ##2 rgb_valid)
        else $error("rgb_valid did not follow pixel_valid by two cycles");

    assert property (@(posedge clk) disable iff (reset) rgb_valid |-> $past(pixel_valid, 2))
        else $error("rgb_valid without a pixel strobe two cycles before");

    assert property (@(posedge clk) reset |=> (!mix_valid && !rgb_valid))
        else $error("valid strobes high during reset");

    assert property (@(posedge clk) $onehot0({prio_sel, pal_sel}))
        else $error("both register selects high");

endmodule

bind video_mixer_top video_mixer_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .pixel_valid (pixel_valid),
    .mix_valid   (mix_valid),
    .rgb_valid   (rgb_valid),
    .prio_sel    (prio_bus.sel),
    .pal_sel     (pal_bus.sel)
);

/* dv/video_mixer_tb.sv */
`timescale 1ns/1ps
`include "video_mixer_macros.svh"

module video_mixer_tb;

    localparam int NUM_OPS = 1083 + 200 + 1224 + 340 + 200 + 10;
    localparam int MAX_CYCLES = NUM_OPS * 4 + 200;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic cs = 1'b0;
    logic [10:0] cpu_addr = '0;
    logic cpu_rw = 1'b0;
    logic [1:0] cpu_ds_n = 2'b11;
    logic [15:0] cpu_din = '0;
    logic [15:0] cpu_dout;
    logic pixel_valid = 1'b0;
    logic [13:0] layer0 = '0;
    logic [13:0] layer1 = '0;
    logic [13:0] layer2 = '0;
    logic rgb_valid;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    logic [31:0] rng = 32'h1760_28b1;
    logic [15:0] ctrl_m [8];
    logic [15:0] pal_m [1024];
    logic [23:0] exp_q [$];
    logic pix_pend = 1'b0;
    logic [9:0] pix_idx;
    logic rd_pend = 1'b0;
    logic [15:0] rd_exp;
    int errors = 0;
    int cycles = 0;
    string cur_test = "reset";

    video_mixer_top uut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] d,
                                          input logic [1:0] ds);
        logic [15:0] r;
        r = old;
        if (!ds[1]) r[15:8] = d[15:8];
        if (!ds[0]) r[7:0] = d[7:0];
        return r;
    endfunction

    // Ties keep the lower layer.
    function automatic logic [13:0] pick_winner(input logic [13:0] l0, input logic [13:0] l1,
                                                input logic [13:0] l2);
        logic [3:0] p0;
        logic [3:0] p1;
        logic [3:0] p2;
        p0 = ctrl_m[2][{l0[13:12], 2'b00} +: 4];
        p1 = ctrl_m[3][{l1[13:12], 2'b00} +: 4];
        p2 = ctrl_m[4][{ctrl_m[0][15:14], 2'b00} +: 4];
        if (p1 > p0) return (p2 > p1) ? l2 : l1;
        return (p2 > p0) ? l2 : l0;
    endfunction

    function automatic logic [23:0] expand(input logic [15:0] w);
        return {w[14:10], w[14:12], w[9:5], w[9:7], w[4:0], w[4:2]};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d, queued outputs left: %0d", errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Each call takes one clock cycle and checks outputs, updates the model and drives inputs.
    task automatic step(input logic c, input logic [10:0] a, input logic rw,
                        input logic [1:0] ds, input logic [15:0] d, input logic pv,
                        input logic [13:0] l0, input logic [13:0] l1, input logic [13:0] l2);
        logic [13:0] w;
        @(negedge clk);
        if (rgb_valid) begin
            if (exp_q.size() == 0) begin
                $display("rgb_valid was high with no pixel expected in %s", cur_test);
                errors++;
            end else begin
                check({cur_test, " rgb"}, exp_q.pop_front(), {red, green, blue});
            end
        end else if (exp_q.size() != 0) begin
            $display("rgb_valid stayed low two cycles after a pixel strobe in %s", cur_test);
            errors++;
            void'(exp_q.pop_front());
        end
        if (rd_pend) begin
            check({cur_test, " read"}, rd_exp, cpu_dout);
            rd_pend = 1'b0;
        end
        // The palette lookup sees the writes of the strobe cycle but not those of this one.
        if (pix_pend) begin
            exp_q.push_back(expand(pal_m[pix_idx]));
            pix_pend = 1'b0;
        end
        cs = c;
        cpu_addr = a;
        cpu_rw = rw;
        cpu_ds_n = ds;
        cpu_din = d;
        pixel_valid = pv;
        layer0 = l0;
        layer1 = l1;
        layer2 = l2;
        if (pv) begin
            w = pick_winner(l0, l1, l2);
            pix_idx = w[9:0];
            pix_pend = 1'b1;
        end
        if (c) begin
            if (rw) begin
                rd_pend = 1'b1;
                if (!a[10]) rd_exp = pal_m[a[9:0]];
                else if (a[9:3] == 0) rd_exp = ctrl_m[a[2:0]];
                else rd_exp = '0;
            end else if (!a[10]) begin
                pal_m[a[9:0]] = merge(pal_m[a[9:0]], d, ds);
            end else if (a[9:3] == 0) begin
                ctrl_m[a[2:0]] = merge(ctrl_m[a[2:0]], d, ds);
            end
        end
    endtask

    task automatic idle();
        step(0, '0, 0, 2'b11, '0, 0, '0, '0, '0);
    endtask

    task automatic cpu_op(input logic [10:0] a, input logic rw, input logic [1:0] ds,
                          input logic [15:0] d);
        step(1, a, rw, ds, d, 0, '0, '0, '0);
    endtask

    task automatic pixel();
        step(0, '0, 0, 2'b11, '0, 1, next_rand(), next_rand(), next_rand());
    endtask

    function automatic logic [10:0] unmapped_addr();
        logic [6:0] mid;
        logic [2:0] low;
        mid = next_rand();
        if (mid == 0) mid = 7'd1;
        low = next_rand();
        return {1'b1, mid, low};
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles in %s", cycles, cur_test);
            errors++;
            report_and_finish();
        end
    end

    initial begin
        logic [31:0] r;
        for (int i = 0; i < 8; i++) ctrl_m[i] = '0;
        for (int i = 0; i < 1024; i++) pal_m[i] = 'x;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check("reset dout", 16'h0, cpu_dout);

        cur_test = "reset state";
        for (int i = 0; i < 1024; i++) cpu_op(i[10:0], 0, 2'b00, next_rand());
        for (int i = 0; i < 8; i++) cpu_op(11'h400 | i[10:0], 1, 2'b00, '0);
        for (int i = 0; i < 50; i++) pixel();

        cur_test = "control registers";
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            case (r[1:0])
                2'd0: cpu_op(11'h400 | r[4:2], 0, r[6:5], next_rand());
                2'd1: cpu_op(11'h400 | r[4:2], 1, 2'b00, '0);
                2'd2: cpu_op(unmapped_addr(), r[7], r[6:5], next_rand());
                default: cpu_op(unmapped_addr(), 1, 2'b00, '0);
            endcase
        end

        cur_test = "palette access";
        for (int i = 0; i < 1024; i++) cpu_op(i[10:0], 0, 2'b00, next_rand());
        for (int i = 0; i < 200; i++) cpu_op(next_rand() & 11'h3ff, 1, 2'b00, '0);

        cur_test = "priority mixing";
        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            // Narrow priorities every so often to force ties.
            if (r[3:0] == 0) cpu_op(11'h400 | (2 + r[5:4] % 3), 0, 2'b00, r[31:16] & 16'h1111);
            else if (r[3:0] == 1) cpu_op(11'h400 | (r[5:4] == 0 ? 0 : 2 + r[5:4] % 3), 0,
                                         2'b00, next_rand());
            pixel();
            repeat (r[7:6]) idle();
        end

        cur_test = "streaming";
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            if (r[1:0] == 0) begin
                step(1, {1'b0, layer0[9:0]}, 0, r[3:2], next_rand(), 1,
                     next_rand(), next_rand(), next_rand());
            end else if (r[1:0] == 1) begin
                step(1, 11'h400 | r[6:4], 0, r[3:2], next_rand(), 1,
                     next_rand(), next_rand(), next_rand());
            end else begin
                pixel();
            end
        end

        repeat (5) idle();
        report_and_finish();
    end

endmodule

/* src.f */
+incdir+source
source/video_mixer_pkg.sv
source/reg_bus_if.sv
source/cpu_bus_decode.sv
source/prio_mixer.sv
source/palette_lookup.sv
source/video_mixer_top.sv
dv/video_mixer_assert.sv
dv/video_mixer_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = video_mixer_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS
FAIL_MSG  = Simulation finished: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
